// ==== verilog/burst_split_pkg.sv ====
// AXI read burst splitter package with bus widths, burst encodings and channel structs
package burst_split_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;

  // AXI length field, beats minus one
  typedef logic [7:0] len_t;

  // AXI size field, log2 of bytes per beat
  typedef logic [2:0] size_t;

  // AXI burst type field
  typedef logic [1:0] burst_t;

  // --------------------------------------------------
  // Encodings
  // --------------------------------------------------
  localparam burst_t BURST_FIXED = 2'b00;
  localparam burst_t BURST_INCR  = 2'b01;

  // Normal access success
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // --------------------------------------------------
  // Channel structs
  // --------------------------------------------------
  // Read address channel, 45 bits
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    len_t                  len;
    size_t                 size;
    burst_t                burst;
  } ar_chan_t;

  // Read data channel, 35 bits
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } r_chan_t;

  // One record per downstream sub-burst
  // final_chunk marks the chunk that closes the original burst
  typedef struct packed {
    logic final_chunk;
    len_t len;
  } sub_burst_t;

endpackage

// ==== verilog/ar_splitter.sv ====
// AR splitter that cuts upstream read bursts into limited sub-bursts and records each one
`timescale 1ns/1ps

module ar_splitter import burst_split_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  input  len_t       len_limit_i,
  // Upstream AR
  input  ar_chan_t   ar_i,
  input  logic       ar_valid_i,
  output logic       ar_ready_o,
  // Downstream AR
  output ar_chan_t   ar_o,
  output logic       ar_valid_o,
  input  logic       ar_ready_i,
  // Sub-burst record towards the FIFO
  output sub_burst_t rec_o,
  output logic       rec_valid_o,
  input  logic       rec_ready_i
);

  typedef enum logic {
    ST_IDLE,
    ST_SPLIT
  } state_e;

  state_e     state_q, state_d;
  // Stored request, address advanced after every chunk
  ar_chan_t   ar_q, ar_d;
  // Beats of the original burst still to be requested
  logic [8:0] beats_q, beats_d;

  // Beats per full chunk
  logic [8:0] max_beats;
  // Beats of the incoming burst
  logic [8:0] total_beats;
  logic [8:0] beats_m1;
  logic       last_chunk;
  len_t       chunk_len;
  logic       chunk_xfer;

  // Address step for one full chunk
  function automatic logic [ADDR_WIDTH-1:0] chunk_step(size_t size, logic [8:0] beats);
    logic [ADDR_WIDTH-1:0] step;
    step = ADDR_WIDTH'(beats) << size;
    return step;
  endfunction

  assign max_beats   = {1'b0, len_limit_i} + 9'd1;
  assign total_beats = {1'b0, ar_i.len} + 9'd1;

  // Remainder chunk once the rest fits into one chunk
  assign beats_m1   = beats_q - 9'd1;
  assign last_chunk = (beats_q <= max_beats);
  assign chunk_len  = last_chunk ? beats_m1[7:0] : len_limit_i;

  // --------------------------------------------------
  // Chunk FSM
  // --------------------------------------------------
  always_comb begin
    state_d           = state_q;
    ar_d              = ar_q;
    beats_d           = beats_q;
    ar_o              = ar_q;
    ar_valid_o        = 1'b0;
    ar_ready_o        = 1'b0;
    rec_o.final_chunk = 1'b0;
    rec_o.len         = len_limit_i;
    chunk_xfer        = 1'b0;

    case (state_q)
      ST_IDLE: begin
        ar_o = ar_i;
        // Nothing is offered downstream unless the FIFO can take its record
        ar_valid_o = ar_valid_i & rec_ready_i;
        if (ar_i.len <= len_limit_i) begin
          // Short burst, fed through as one final chunk
          rec_o.final_chunk = 1'b1;
          rec_o.len         = ar_i.len;
          chunk_xfer        = ar_valid_o & ar_ready_i;
          ar_ready_o        = chunk_xfer;
        end else begin
          // Long burst, capture it and offer the first full chunk right away
          ar_o.len   = len_limit_i;
          chunk_xfer = ar_valid_o & ar_ready_i;
          ar_ready_o = ar_valid_o;
          if (ar_valid_o) begin
            ar_d    = ar_i;
            beats_d = total_beats;
            state_d = ST_SPLIT;
            if (chunk_xfer) begin
              beats_d = total_beats - max_beats;
              if (ar_i.burst == BURST_INCR) begin
                ar_d.addr = ar_i.addr + chunk_step(ar_i.size, max_beats);
              end
            end
          end
        end
      end

      ST_SPLIT: begin
        ar_o.len          = chunk_len;
        rec_o.final_chunk = last_chunk;
        rec_o.len         = chunk_len;
        ar_valid_o        = rec_ready_i;
        chunk_xfer        = ar_valid_o & ar_ready_i;
        if (chunk_xfer) begin
          if (last_chunk) begin
            state_d = ST_IDLE;
          end else begin
            beats_d = beats_q - max_beats;
            // FIXED bursts keep the same address on every chunk
            if (ar_q.burst == BURST_INCR) begin
              ar_d.addr = ar_q.addr + chunk_step(ar_q.size, max_beats);
            end
          end
        end
      end
    endcase
  end

  // One record for every chunk taken downstream
  assign rec_valid_o = chunk_xfer;

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
      beats_q <= 9'd0;
    end else begin
      state_q <= state_d;
      beats_q <= beats_d;
    end
  end

  always_ff @(posedge clk_i) begin
    ar_q <= ar_d;
  end

  // --------------------------------------------------
  // Assertions
  // --------------------------------------------------
  // No chunk may exceed the programmed limit
  assert property (@(posedge clk_i) disable iff (reset_i)
    ar_valid_o |-> ar_o.len <= len_limit_i)
    else $error("AR chunk longer than the length limit");

  // An offered chunk stays put until taken, FIFO room cannot vanish meanwhile
  assert property (@(posedge clk_i) disable iff (reset_i)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
    else $error("AR chunk withdrawn or changed before transfer");

endmodule

// ==== verilog/sub_burst_fifo.sv ====
// In-order FIFO of outstanding sub-burst records between AR splitter and R rebuilder
`timescale 1ns/1ps

module sub_burst_fifo import burst_split_pkg::*; #(
  parameter int DEPTH = 4
) (
  input  logic       clk_i,
  input  logic       reset_i,
  // Write side
  input  sub_burst_t push_i,
  input  logic       push_valid_i,
  output logic       push_ready_o,
  // Read side
  output sub_burst_t pop_o,
  output logic       pop_valid_o,
  input  logic       pop_ready_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Record storage
  sub_burst_t mem_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  logic push;
  logic pop;

  // Flags come from the count only, so no path from pop to push
  assign push_ready_o = (count_q != CNT_W'(DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign pop_o        = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_ready_i & pop_valid_o;

  // Pointer and occupancy
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        // Wrap at the last slot, depth need not be a power of two
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage write
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_i;
    end
  end

  // --------------------------------------------------
  // Assertions
  // --------------------------------------------------
  // Splitter only pushes with room left
  assert property (@(posedge clk_i) disable iff (reset_i)
    push_valid_i |-> push_ready_o)
    else $error("Sub-burst FIFO pushed while full");

  // Rebuilder only pops a record it has seen
  assert property (@(posedge clk_i) disable iff (reset_i)
    pop_ready_i |-> pop_valid_o)
    else $error("Sub-burst FIFO popped while empty");

endmodule

// ==== verilog/r_last_rebuild.sv ====
// R last rebuilder that counts beats per sub-burst and raises upstream last on the final one
`timescale 1ns/1ps

module r_last_rebuild import burst_split_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  // Downstream R
  input  r_chan_t    m_r_i,
  input  logic       m_r_valid_i,
  output logic       m_r_ready_o,
  // Upstream R
  output r_chan_t    s_r_o,
  output logic       s_r_valid_o,
  input  logic       s_r_ready_i,
  // Head record of the sub-burst FIFO
  input  sub_burst_t rec_i,
  input  logic       rec_valid_i,
  output logic       rec_ready_o
);

  // Beat index inside the head sub-burst
  len_t beat_cnt_q;

  // Current beat closes the head sub-burst
  logic chunk_end;
  // Beat moves upstream this cycle
  logic beat_xfer;

  // --------------------------------------------------
  // End detection
  // --------------------------------------------------
  // Counted against the record, downstream last is not trusted here
  assign chunk_end = (beat_cnt_q == rec_i.len);

  // --------------------------------------------------
  // Handshake
  // --------------------------------------------------
  // Beats only flow while a record is known
  assign s_r_valid_o = m_r_valid_i & rec_valid_i;

  // Upstream stall holds the downstream beat in the same cycle
  assign m_r_ready_o = s_r_ready_i & rec_valid_i;

  assign beat_xfer = m_r_valid_i & m_r_ready_o;

  // Pop on the last beat of every sub-burst
  assign rec_ready_o = beat_xfer & chunk_end;

  // --------------------------------------------------
  // Payload
  // --------------------------------------------------
  always_comb begin
    s_r_o.data = m_r_i.data;
    s_r_o.resp = m_r_i.resp;
    // Intermediate chunk ends stay hidden from upstream
    s_r_o.last = chunk_end & rec_i.final_chunk;
  end

  // --------------------------------------------------
  // Beat counter
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      beat_cnt_q <= '0;
    end else if (beat_xfer) begin
      if (chunk_end) begin
        // Next beat starts a fresh sub-burst
        beat_cnt_q <= '0;
      end else begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Assertions
  // --------------------------------------------------
  // Slave last must match the length the splitter requested
  assert property (@(posedge clk_i) disable iff (reset_i)
    m_r_valid_i && rec_valid_i |-> m_r_i.last == chunk_end)
    else $error("Downstream R last disagrees with sub-burst length");

  // A downstream beat never shows up without an outstanding sub-burst
  assert property (@(posedge clk_i) disable iff (reset_i)
    m_r_valid_i |-> rec_valid_i)
    else $error("Downstream R beat with no sub-burst outstanding");

endmodule

// ==== verilog/burst_splitter_top.sv ====
// AXI read burst splitter top joining AR splitter, sub-burst FIFO and R last rebuilder
`timescale 1ns/1ps

module burst_splitter_top import burst_split_pkg::*; #(
  // Sub-bursts outstanding at once
  parameter int MAX_TXNS = 4
) (
  input  logic     clk_i,
  input  logic     reset_i,
  // Beats per chunk minus one, changed only while idle
  input  len_t     len_limit_i,
  // Upstream AR
  input  ar_chan_t s_ar_i,
  input  logic     s_ar_valid_i,
  output logic     s_ar_ready_o,
  // Downstream AR
  output ar_chan_t m_ar_o,
  output logic     m_ar_valid_o,
  input  logic     m_ar_ready_i,
  // Downstream R
  input  r_chan_t  m_r_i,
  input  logic     m_r_valid_i,
  output logic     m_r_ready_o,
  // Upstream R
  output r_chan_t  s_r_o,
  output logic     s_r_valid_o,
  input  logic     s_r_ready_i
);

  // --------------------------------------------------
  // Record path
  // --------------------------------------------------
  // Splitter to FIFO
  sub_burst_t push_rec;
  logic       push_valid;
  logic       push_ready;

  // FIFO head to rebuilder
  sub_burst_t head_rec;
  logic       head_valid;
  logic       head_ready;

  // Producer, one record per downstream chunk
  ar_splitter u_ar_splitter (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .len_limit_i (len_limit_i),
    .ar_i        (s_ar_i),
    .ar_valid_i  (s_ar_valid_i),
    .ar_ready_o  (s_ar_ready_o),
    .ar_o        (m_ar_o),
    .ar_valid_o  (m_ar_valid_o),
    .ar_ready_i  (m_ar_ready_i),
    .rec_o       (push_rec),
    .rec_valid_o (push_valid),
    .rec_ready_i (push_ready)
  );

  // Buffer, responses come back in request order
  sub_burst_fifo #(
    .DEPTH (MAX_TXNS)
  ) u_sub_burst_fifo (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .push_i       (push_rec),
    .push_valid_i (push_valid),
    .push_ready_o (push_ready),
    .pop_o        (head_rec),
    .pop_valid_o  (head_valid),
    .pop_ready_i  (head_ready)
  );

  // Consumer, restores last of the original burst
  r_last_rebuild u_r_last_rebuild (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .m_r_i       (m_r_i),
    .m_r_valid_i (m_r_valid_i),
    .m_r_ready_o (m_r_ready_o),
    .s_r_o       (s_r_o),
    .s_r_valid_o (s_r_valid_o),
    .s_r_ready_i (s_r_ready_i),
    .rec_i       (head_rec),
    .rec_valid_i (head_valid),
    .rec_ready_o (head_ready)
  );

endmodule

// ==== bench/tb_mem_model.sv ====
// Downstream AXI read slave model answering sub-bursts in order with address-derived data
`timescale 1ns/1ps

module tb_mem_model import burst_split_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  // AR from the DUT
  input  ar_chan_t ar_i,
  input  logic     ar_valid_i,
  output logic     ar_ready_o,
  // R towards the DUT
  output r_chan_t  r_o,
  output logic     r_valid_o,
  input  logic     r_ready_i,
  // Random go bits, changed on the rising edge
  input  logic     ar_go_i,
  input  logic     r_go_i
);

  // Accepted chunks waiting for data
  ar_chan_t    pend[$];
  // Beat index inside the head chunk
  int unsigned beat;
  // R beat taken on the last rising edge
  logic        r_took;

  // Address of beat k of a chunk
  function automatic logic [ADDR_WIDTH-1:0] beat_addr(ar_chan_t ar, int unsigned k);
    if (ar.burst == BURST_FIXED) begin
      return ar.addr;
    end
    return ar.addr + (ADDR_WIDTH'(k) << ar.size);
  endfunction

  initial begin
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_o        = '0;
    beat       = 0;
    r_took     = 1'b0;
  end

  // --------------------------------------------------
  // Handshakes seen at the rising edge
  // --------------------------------------------------
  always @(posedge clk_i) begin
    r_took = r_valid_o && r_ready_i;
    if (reset_i) begin
      pend.delete();
      beat = 0;
    end else begin
      if (r_took) begin
        if (beat == int'(pend[0].len)) begin
          pend.pop_front();
          beat = 0;
        end else begin
          beat++;
        end
      end
      if (ar_valid_i && ar_ready_o) begin
        pend.push_back(ar_i);
      end
    end
  end

  // --------------------------------------------------
  // Outputs driven on the falling edge
  // --------------------------------------------------
  always @(negedge clk_i) begin
    ar_ready_o = ar_go_i && (pend.size() < 8);
    // Valid held until the beat is taken
    if (!r_valid_o || r_took) begin
      r_valid_o = (pend.size() != 0) && r_go_i;
    end
    if (pend.size() != 0) begin
      r_o.data = beat_addr(pend[0], beat);
      r_o.resp = RESP_OKAY;
      r_o.last = (beat == int'(pend[0].len));
    end
  end

endmodule

// ==== bench/tb_burst_splitter.sv ====
// Testbench for the AXI read burst splitter with a stimulus table and an in-order memory model
`timescale 1ns/1ps

module tb_burst_splitter import burst_split_pkg::*; ();

  // One table row holding the original burst and the limit in force
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    len_t                  len;
    size_t                 size;
    burst_t                burst;
    len_t                  limit;
  } stim_t;

  localparam int NUM_STIM = 10;
  localparam stim_t STIM [NUM_STIM] = '{
    '{32'h0000_1000, 8'd3,  3'd2, BURST_INCR,  8'd7},   // Pass-through
    '{32'h0000_2000, 8'd7,  3'd2, BURST_INCR,  8'd7},   // Exactly at the limit
    '{32'h0000_3000, 8'd15, 3'd2, BURST_INCR,  8'd3},   // Four even chunks
    '{32'h0000_4010, 8'd9,  3'd3, BURST_INCR,  8'd3},   // Remainder chunk
    '{32'h0000_5004, 8'd11, 3'd2, BURST_FIXED, 8'd4},
    '{32'h0000_6000, 8'd15, 3'd2, BURST_INCR,  8'd0},   // Single beats that fill the FIFO
    '{32'h0000_7000, 8'd5,  3'd1, BURST_FIXED, 8'd0},
    '{32'h0000_8000, 8'd0,  3'd2, BURST_INCR,  8'd0},
    '{32'h0000_9000, 8'd63, 3'd2, BURST_INCR,  8'd15},
    '{32'h0000_a001, 8'd20, 3'd0, BURST_INCR,  8'd6}
  };

  logic     clk_i;
  logic     reset_i;
  len_t     len_limit_i;
  ar_chan_t s_ar_i;
  logic     s_ar_valid_i;
  logic     s_ar_ready_o;
  ar_chan_t m_ar_o;
  logic     m_ar_valid_o;
  logic     m_ar_ready_i;
  r_chan_t  m_r_i;
  logic     m_r_valid_i;
  logic     m_r_ready_o;
  r_chan_t  s_r_o;
  logic     s_r_valid_o;
  logic     s_r_ready_i;
  logic     ar_go;
  logic     r_go;

  logic [31:0] lfsr = 32'hd31e5b96;
  int          checks = 0;
  int          errors = 0;
  ar_chan_t    got_ar[$];
  r_chan_t     got_r[$];

  burst_splitter_top #(.MAX_TXNS(4)) dut (
    .clk_i, .reset_i, .len_limit_i,
    .s_ar_i, .s_ar_valid_i, .s_ar_ready_o,
    .m_ar_o, .m_ar_valid_o, .m_ar_ready_i,
    .m_r_i, .m_r_valid_i, .m_r_ready_o,
    .s_r_o, .s_r_valid_o, .s_r_ready_i
  );

  tb_mem_model u_mem (
    .clk_i, .reset_i,
    .ar_i (m_ar_o), .ar_valid_i (m_ar_valid_o), .ar_ready_o (m_ar_ready_i),
    .r_o (m_r_i), .r_valid_o (m_r_valid_i), .r_ready_i (m_r_ready_o),
    .ar_go_i (ar_go), .r_go_i (r_go)
  );

  always #10 clk_i = ~clk_i;

  // --------------------------------------------------
  // Random stalls
  // --------------------------------------------------
  // Galois LFSR for x^32 + x^22 + x^2 + x + 1
  // One step per bit
  function automatic logic rand_bit();
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    return lfsr[0];
  endfunction

  // High three times out of four
  function automatic logic likely_bit();
    logic b0;
    logic b1;
    b0 = rand_bit();
    b1 = rand_bit();
    return b0 | b1;
  endfunction

  // Model go bits settle well before its falling-edge update
  always @(posedge clk_i) begin
    ar_go = likely_bit();
    r_go  = likely_bit();
  end

  always @(negedge clk_i) begin
    s_r_ready_i = likely_bit();
  end

  // Transfers captured on both monitored channels
  always @(posedge clk_i) begin
    if (!reset_i && m_ar_valid_o && m_ar_ready_i) begin
      got_ar.push_back(m_ar_o);
    end
    if (!reset_i && s_r_valid_o && s_r_ready_i) begin
      got_r.push_back(s_r_o);
    end
  end

  // Upstream stall holds the downstream R beat in the same cycle
  always @(posedge clk_i) begin
    if (!reset_i && !s_r_ready_i) begin
      compare_value("m_r_ready_o", m_r_ready_o, 1'b0);
    end
  end

  // --------------------------------------------------
  // Checks and report
  // --------------------------------------------------
  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  // Chunk sequence rebuilt from the length limit rule
  task automatic check_chunks(input stim_t e);
    int unsigned left;
    int unsigned clen;
    int unsigned idx;
    logic [ADDR_WIDTH-1:0] addr;
    left = e.len + 1;
    addr = e.addr;
    idx  = 0;
    while (left != 0) begin
      clen = (left > e.limit + 1) ? e.limit + 1 : left;
      if (idx < got_ar.size()) begin
        compare_value("m_ar.addr", got_ar[idx].addr, addr);
        compare_value("m_ar.len", got_ar[idx].len, clen - 1);
        compare_value("m_ar.size", got_ar[idx].size, e.size);
        compare_value("m_ar.burst", got_ar[idx].burst, e.burst);
      end
      left = left - clen;
      if (e.burst == BURST_INCR) begin
        addr = addr + (clen << e.size);
      end
      idx++;
    end
    compare_value("m_ar chunk count", got_ar.size(), idx);
  endtask

  // Upstream beats of the original burst
  task automatic verify_beats(input stim_t e);
    logic [ADDR_WIDTH-1:0] exp_addr;
    for (int k = 0; k <= int'(e.len); k++) begin
      if (k < got_r.size()) begin
        exp_addr = (e.burst == BURST_INCR) ? e.addr + (k << e.size) : e.addr;
        compare_value("s_r.data", got_r[k].data, exp_addr);
        compare_value("s_r.resp", got_r[k].resp, RESP_OKAY);
        compare_value("s_r.last", got_r[k].last, k == int'(e.len));
      end
    end
    compare_value("s_r beat count", got_r.size(), e.len + 1);
  endtask

  task automatic report_and_finish();
    $display("Checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  // Eight clock periods per table beat plus reset
  function automatic longint watchdog_ns();
    longint beats = 0;
    for (int i = 0; i < NUM_STIM; i++) begin
      beats += STIM[i].len + 1;
    end
    return beats * 20 * 8 + 16 * 20;
  endfunction

  initial begin
    longint limit_ns;
    limit_ns = watchdog_ns();
    #(limit_ns);
    errors++;
    $display("Timeout: the table did not finish within %0d ns", limit_ns);
    report_and_finish();
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  task automatic send_ar(input ar_chan_t ar);
    s_ar_i       = ar;
    s_ar_valid_i = 1'b1;
    do begin
      @(posedge clk_i);
    end while (!s_ar_ready_o);
    @(negedge clk_i);
    s_ar_valid_i = 1'b0;
  endtask

  initial begin
    stim_t    e;
    ar_chan_t ar;
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    len_limit_i  = '0;
    s_ar_i       = '0;
    s_ar_valid_i = 1'b0;
    s_r_ready_i  = 1'b0;
    ar_go        = 1'b0;
    r_go         = 1'b0;
    repeat (16) @(negedge clk_i);
    // Quiet outputs while reset is held
    compare_value("s_ar_ready_o", s_ar_ready_o, 1'b0);
    compare_value("m_ar_valid_o", m_ar_valid_o, 1'b0);
    compare_value("s_r_valid_o", s_r_valid_o, 1'b0);
    reset_i = 1'b0;
    repeat (2) @(negedge clk_i);
    for (int i = 0; i < NUM_STIM; i++) begin
      e           = STIM[i];
      len_limit_i = e.limit;
      ar.addr     = e.addr;
      ar.len      = e.len;
      ar.size     = e.size;
      ar.burst    = e.burst;
      send_ar(ar);
      // Original burst done once upstream last shows up
      while (got_r.size() == 0 || !got_r[got_r.size() - 1].last) begin
        @(negedge clk_i);
      end
      check_chunks(e);
      verify_beats(e);
      got_ar.delete();
      got_r.delete();
    end
    report_and_finish();
  end

endmodule

// ==== compile.f ====
verilog/burst_split_pkg.sv
verilog/ar_splitter.sv
verilog/sub_burst_fifo.sv
verilog/r_last_rebuild.sv
verilog/burst_splitter_top.sv
bench/tb_mem_model.sv
bench/tb_burst_splitter.sv

// ==== Makefile ====
# Verilator build and run for the AXI read burst splitter

VERILATOR ?= verilator
TOP       ?= tb_burst_splitter
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
PASS_MSG  ?= Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	  echo "$$out"; \
	  echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
